//--- verilog/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// CPU side widths
`define DCACHE_ADDR_WIDTH 32
`define DCACHE_WORD_WIDTH 32

// Geometry, 16 sets of 2 ways with 16-byte lines
`define DCACHE_LINE_WORDS 4
`define DCACHE_SETS       16
`define DCACHE_WAYS       2

`endif

//--- verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    // Address split
    localparam int BYTE_BITS   = $clog2(`DCACHE_WORD_WIDTH / 8);
    localparam int OFFSET_BITS = $clog2(`DCACHE_LINE_WORDS);
    localparam int INDEX_BITS  = $clog2(`DCACHE_SETS);
    localparam int LINE_BITS   = OFFSET_BITS + BYTE_BITS;
    localparam int TAG_BITS    = `DCACHE_ADDR_WIDTH - INDEX_BITS - LINE_BITS;

    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0]    tag_bits_t;
    typedef logic [`DCACHE_WAYS-1:0] way_vec_t;

    typedef struct packed {
        logic      valid;
        logic      dirty;
        tag_bits_t tag;
    } tag_entry_t;

    typedef logic [`DCACHE_LINE_WORDS-1:0][`DCACHE_WORD_WIDTH-1:0] line_t;

    // One CPU access as it moves down the pipeline
    typedef struct packed {
        logic                            read;
        logic                            write;
        logic [`DCACHE_ADDR_WIDTH-1:0]   addr;
        logic [`DCACHE_WORD_WIDTH-1:0]   wdata;
        logic [`DCACHE_WORD_WIDTH/8-1:0] be;
    } stage_req_t;

    function automatic index_t get_index(input logic [`DCACHE_ADDR_WIDTH-1:0] addr);
        return addr[LINE_BITS +: INDEX_BITS];
    endfunction

    function automatic tag_bits_t get_tag(input logic [`DCACHE_ADDR_WIDTH-1:0] addr);
        return addr[`DCACHE_ADDR_WIDTH-1 -: TAG_BITS];
    endfunction

    function automatic offset_t get_offset(input logic [`DCACHE_ADDR_WIDTH-1:0] addr);
        return addr[BYTE_BITS +: OFFSET_BITS];
    endfunction

    // Byte lanes with be set come from new_word
    function automatic logic [`DCACHE_WORD_WIDTH-1:0] merge_bytes(
        input logic [`DCACHE_WORD_WIDTH-1:0]   old_word,
        input logic [`DCACHE_WORD_WIDTH-1:0]   new_word,
        input logic [`DCACHE_WORD_WIDTH/8-1:0] be
    );
        logic [`DCACHE_WORD_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < `DCACHE_WORD_WIDTH / 8; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

//--- verilog/dcache_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

// Stage-2 view: the request and everything read from its set
interface dcache_stage_if
    import dcache_pkg::*;
();
    stage_req_t                    s2;
    way_vec_t                      hit;
    tag_entry_t [`DCACHE_WAYS-1:0] tags;
    line_t      [`DCACHE_WAYS-1:0] lines;
    logic                          miss;

    modport decode  (output s2, hit, tags, lines, miss);
    modport result  (input hit, lines);
    modport execute (input s2, hit, tags, lines, miss);
endinterface

// Stage-3 state shared between the miss controller and the data path
interface dcache_fill_if
    import dcache_pkg::*;
();
    stage_req_t s3;
    logic       fwd;
    line_t      refill_buf;
    logic       fill_done;
    // Stage-2 line after way select and forwarding
    line_t      s2_line;

    modport execute (output s3, fwd, refill_buf, fill_done, input s2_line);
    modport result  (input s3, fwd, refill_buf, output s2_line);
endinterface

`default_nettype wire

//--- verilog/dcache_ram.sv
`timescale 1ns/1ns
`default_nettype none

// Single write port, single read port, one cycle read latency
module dcache_ram
    import dcache_pkg::*;
#(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           we,
    input  wire index_t   waddr,
    input  wire payload_t wdata,
    input  wire           re,
    input  wire index_t   raddr,
    output payload_t      rdata
);
    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Write-first on an address collision, output holds while re is low
        if (re) begin
            if (we && waddr == raddr) begin
                rdata <= wdata;
            end else begin
                rdata <= mem[raddr];
            end
        end
    end
endmodule

`default_nettype wire

//--- verilog/dcache_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache_decode
    import dcache_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  cpu_read,
    input  wire                                  cpu_write,
    input  wire [`DCACHE_ADDR_WIDTH-1:0]         cpu_addr,
    input  wire [`DCACHE_WORD_WIDTH-1:0]         cpu_wdata,
    input  wire [`DCACHE_WORD_WIDTH/8-1:0]       cpu_byteenable,
    input  wire                                  stall,
    output index_t                               ram_raddr,
    input  wire tag_entry_t [`DCACHE_WAYS-1:0]   tag_rdata,
    input  wire line_t [`DCACHE_WAYS-1:0]        line_rdata,
    dcache_stage_if.decode                       stage
);
    stage_req_t s2;
    logic       s2_valid;

    // Hold the stage-2 set while stalled so a refill can be re-read
    assign ram_raddr = stall ? get_index(s2.addr) : get_index(cpu_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            s2.read  <= 1'b0;
            s2.write <= 1'b0;
        end else if (!stall) begin
            s2.read  <= cpu_read;
            s2.write <= cpu_write;
            s2.addr  <= cpu_addr;
            s2.wdata <= cpu_wdata;
            s2.be    <= cpu_byteenable;
        end
    end

    assign s2_valid = s2.read || s2.write;

    // Tag compare across all ways
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            stage.hit[w] = s2_valid && tag_rdata[w].valid
                           && tag_rdata[w].tag == get_tag(s2.addr);
        end
    end

    assign stage.miss  = s2_valid && !(|stage.hit);
    assign stage.s2    = s2;
    assign stage.tags  = tag_rdata;
    assign stage.lines = line_rdata;
endmodule

`default_nettype wire

//--- verilog/dcache_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache_execute
    import dcache_pkg::*;
(
    input  wire                              clk,
    input  wire                              rst,
    dcache_stage_if.execute                  stage,
    dcache_fill_if.execute                   fill,
    input  wire line_t                       merged_line,
    output logic                             stall,
    output way_vec_t                         ram_we,
    output index_t                           ram_waddr,
    output tag_entry_t                       tag_wdata,
    output logic                             mem_rd,
    output logic                             mem_wr,
    output logic [`DCACHE_ADDR_WIDTH-1:0]    mem_addr,
    output logic [`DCACHE_WORD_WIDTH-1:0]    mem_wdata,
    input  wire                              mem_rvalid,
    input  wire [`DCACHE_WORD_WIDTH-1:0]     mem_rdata,
    input  wire                              mem_wready
);
    localparam int WAY_BITS = $clog2(`DCACHE_WAYS);

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        WRITEBACK,
        REFILL,
        FINISH
    } state_t;

    state_t              state;
    stage_req_t          s3;
    logic                s3_miss;
    way_vec_t            s3_hit;
    logic [WAY_BITS-1:0] victim_way;
    tag_entry_t          victim_tag;
    line_t               line_buf;
    offset_t             burst_cnt;
    index_t              sweep_cnt;
    logic [7:0]          lfsr;
    logic                advance;
    logic                write_hit;
    logic                last_beat;
    logic                victim_patch;
    logic [WAY_BITS-1:0] new_victim;

    assign stall      = state != IDLE || s3_miss;
    assign advance    = !stall;
    assign write_hit  = s3.write && |s3_hit;
    assign last_beat  = burst_cnt == offset_t'(`DCACHE_LINE_WORDS - 1);
    assign new_victim = lfsr[WAY_BITS-1:0];

    // Victim set is being written by the stage-3 hit in this same cycle
    assign victim_patch = write_hit && s3_hit[new_victim]
                          && get_index(s3.addr) == get_index(stage.s2.addr);

    assign fill.s3         = s3;
    assign fill.refill_buf = line_buf;
    assign fill.fill_done  = state == FINISH;
    assign fill.fwd = s3.write && (stage.s2.read || stage.s2.write)
                      && s3.addr[`DCACHE_ADDR_WIDTH-1:LINE_BITS]
                         == stage.s2.addr[`DCACHE_ADDR_WIDTH-1:LINE_BITS];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SWEEP;
            sweep_cnt <= '0;
            burst_cnt <= '0;
            lfsr      <= 8'h01;
            s3.read   <= 1'b0;
            s3.write  <= 1'b0;
            s3_miss   <= 1'b0;
        end else begin
            case (state)
                SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == index_t'(`DCACHE_SETS - 1)) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (s3_miss) begin
                        state <= (victim_tag.valid && victim_tag.dirty) ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (mem_wready) begin
                        burst_cnt <= burst_cnt + 1'b1;
                        if (last_beat) begin
                            state <= REFILL;
                        end
                    end
                end
                REFILL: begin
                    if (mem_rvalid) begin
                        burst_cnt <= burst_cnt + 1'b1;
                        if (last_beat) begin
                            state <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    state   <= IDLE;
                    s3_miss <= 1'b0;
                end
                default: state <= IDLE;
            endcase

            if (advance) begin
                s3      <= stage.s2;
                s3_miss <= stage.miss;
                // Fibonacci feedback for x^8 + x^6 + x^5 + x^4 + 1
                if (stage.miss) begin
                    lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                end
            end
        end
    end

    // Line buffer holds the hit line, or the victim and then the refill
    always_ff @(posedge clk) begin
        if (advance) begin
            s3_hit     <= stage.hit;
            victim_way <= new_victim;
            if (!stage.miss) begin
                line_buf <= fill.s2_line;
            end else if (victim_patch) begin
                victim_tag <= '{valid: 1'b1, dirty: 1'b1, tag: get_tag(s3.addr)};
                line_buf   <= merged_line;
            end else begin
                victim_tag <= stage.tags[new_victim];
                line_buf   <= stage.lines[new_victim];
            end
        end else if (state == REFILL && mem_rvalid) begin
            line_buf[burst_cnt] <= mem_rdata;
        end
    end

    always_comb begin
        ram_we    = '0;
        ram_waddr = get_index(s3.addr);
        tag_wdata = '{valid: 1'b1, dirty: s3.write, tag: get_tag(s3.addr)};
        case (state)
            SWEEP: begin
                ram_we    = '1;
                ram_waddr = sweep_cnt;
                tag_wdata = '0;
            end
            IDLE: begin
                if (write_hit) begin
                    ram_we = s3_hit;
                end
            end
            FINISH:  ram_we[victim_way] = 1'b1;
            default: ram_we = '0;
        endcase
    end

    assign mem_rd    = state == REFILL;
    assign mem_wr    = state == WRITEBACK;
    assign mem_wdata = line_buf[burst_cnt];
    assign mem_addr  = mem_wr
        ? {victim_tag.tag, get_index(s3.addr), {LINE_BITS{1'b0}}}
        : {s3.addr[`DCACHE_ADDR_WIDTH-1:LINE_BITS], {LINE_BITS{1'b0}}};
endmodule

`default_nettype wire

//--- verilog/dcache_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache_result
    import dcache_pkg::*;
(
    dcache_stage_if.result                 stage,
    dcache_fill_if.result                  fill,
    output line_t                          merged_line,
    output logic [`DCACHE_WORD_WIDTH-1:0]  cpu_rdata
);
    offset_t s3_off;
    line_t   hit_line;

    assign s3_off = get_offset(fill.s3.addr);

    // Stage 2 way select
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (stage.hit[w]) begin
                hit_line = stage.lines[w];
            end
        end
    end

    // A stage-3 write to the same line has not reached the RAM yet
    always_comb begin
        fill.s2_line = hit_line;
        if (fill.fwd) begin
            fill.s2_line[s3_off] = merge_bytes(hit_line[s3_off], fill.s3.wdata, fill.s3.be);
        end
    end

    // Line stored back on a write hit or at the end of a refill
    always_comb begin
        merged_line = fill.refill_buf;
        if (fill.s3.write) begin
            merged_line[s3_off] = merge_bytes(fill.refill_buf[s3_off], fill.s3.wdata,
                                              fill.s3.be);
        end
    end

    assign cpu_rdata = fill.refill_buf[s3_off];
endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  wire                              clk,
    input  wire                              rst,
    // CPU side
    input  wire                              cpu_read,
    input  wire                              cpu_write,
    input  wire [`DCACHE_ADDR_WIDTH-1:0]     cpu_addr,
    input  wire [`DCACHE_WORD_WIDTH-1:0]     cpu_wdata,
    input  wire [`DCACHE_WORD_WIDTH/8-1:0]   cpu_byteenable,
    output logic                             cpu_stall,
    output logic                             cpu_rvalid,
    output logic [`DCACHE_WORD_WIDTH-1:0]    cpu_rdata,
    // Memory side
    output logic                             mem_rd,
    output logic                             mem_wr,
    output logic [`DCACHE_ADDR_WIDTH-1:0]    mem_addr,
    output logic [`DCACHE_WORD_WIDTH-1:0]    mem_wdata,
    input  wire                              mem_rvalid,
    input  wire [`DCACHE_WORD_WIDTH-1:0]     mem_rdata,
    input  wire                              mem_wready
);
    index_t                        ram_raddr;
    index_t                        ram_waddr;
    way_vec_t                      ram_we;
    logic                          ram_re;
    tag_entry_t                    tag_wdata;
    tag_entry_t [`DCACHE_WAYS-1:0] tag_rdata;
    line_t      [`DCACHE_WAYS-1:0] line_rdata;
    line_t                         merged_line;

    dcache_stage_if u_stage_if ();
    dcache_fill_if  u_fill_if ();

    // Read port idles during a miss except for the re-read at FINISH
    assign ram_re     = !cpu_stall || u_fill_if.fill_done;
    assign cpu_rvalid = u_fill_if.s3.read && !cpu_stall;

    dcache_decode u_decode (
        .clk, .rst, .cpu_read, .cpu_write, .cpu_addr, .cpu_wdata, .cpu_byteenable,
        .stall      (cpu_stall),
        .ram_raddr  (ram_raddr),
        .tag_rdata  (tag_rdata),
        .line_rdata (line_rdata),
        .stage      (u_stage_if.decode)
    );

    dcache_execute u_execute (
        .clk, .rst,
        .stage       (u_stage_if.execute),
        .fill        (u_fill_if.execute),
        .merged_line (merged_line),
        .stall       (cpu_stall),
        .ram_we, .ram_waddr, .tag_wdata,
        .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata, .mem_wready
    );

    dcache_result u_result (
        .stage       (u_stage_if.result),
        .fill        (u_fill_if.result),
        .merged_line (merged_line),
        .cpu_rdata   (cpu_rdata)
    );

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dcache_ram #(.DEPTH(`DCACHE_SETS), .payload_t(tag_entry_t)) u_tag_ram (
            .clk, .we(ram_we[w]), .waddr(ram_waddr), .wdata(tag_wdata),
            .re(ram_re), .raddr(ram_raddr), .rdata(tag_rdata[w])
        );

        dcache_ram #(.DEPTH(`DCACHE_SETS), .payload_t(line_t)) u_line_ram (
            .clk, .we(ram_we[w]), .waddr(ram_waddr), .wdata(merged_line),
            .re(ram_re), .raddr(ram_raddr), .rdata(line_rdata[w])
        );
    end
endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

// Backing memory, each burst beat comes after 0 to 3 idle cycles
module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  wire                                   clk,
    input  wire                                   mem_rd,
    input  wire                                   mem_wr,
    input  wire [31:0]                            mem_addr,
    input  wire [31:0]                            mem_wdata,
    output logic                                  mem_rvalid,
    output logic [31:0]                           mem_rdata,
    output logic                                  mem_wready,
    output logic                                  wb_done,
    output logic [31:0]                           wb_addr,
    output logic [`DCACHE_LINE_WORDS-1:0][31:0]   wb_line
);
    logic [31:0] words [logic [29:0]];

    // Every word address gets its own value
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5ace_0f17;
    endfunction

    task automatic read_burst();
        logic [31:0] addr;
        addr = mem_addr;
        for (int beat = 0; beat < `DCACHE_LINE_WORDS; beat++) begin
            repeat ($urandom % 4) @(negedge clk);
            mem_rdata  = words.exists(addr[31:2]) ? words[addr[31:2]] : initial_word(addr);
            mem_rvalid = 1'b1;
            @(negedge clk);
            mem_rvalid = 1'b0;
            addr = addr + 32'd4;
        end
    endtask

    // Last beat also raises wb_done for one cycle with the whole line
    task automatic write_burst();
        logic [31:0] addr;
        addr    = mem_addr;
        wb_addr = mem_addr;
        for (int beat = 0; beat < `DCACHE_LINE_WORDS; beat++) begin
            repeat ($urandom % 4) @(negedge clk);
            mem_wready         = 1'b1;
            words[addr[31:2]]  = mem_wdata;
            wb_line[beat]      = mem_wdata;
            wb_done            = beat == `DCACHE_LINE_WORDS - 1;
            @(negedge clk);
            mem_wready = 1'b0;
            wb_done    = 1'b0;
            addr = addr + 32'd4;
        end
    endtask

    initial begin
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_wready = 1'b0;
        wb_done    = 1'b0;
        wb_addr    = '0;
        wb_line    = '0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            if (mem_wr) begin
                write_burst();
            end else if (mem_rd) begin
                read_burst();
            end
        end
    end
endmodule

`default_nettype wire

//--- sim/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module tb_dcache;
    localparam logic [31:0] SEED      = 32'h3f1c_1eca;
    localparam int N_ENTRIES          = 20;
    localparam int RESET_CYCLES       = 8;
    localparam int WATCHDOG_CYCLES    = N_ENTRIES * 64 + `DCACHE_SETS + RESET_CYCLES;
    localparam logic [1:0] OP_RD      = 2'd1;
    localparam logic [1:0] OP_WR      = 2'd2;

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        // Read must return two edges after acceptance
        logic        fast;
    } entry_t;

    typedef struct {
        logic [31:0] data;
        int          tick;
        logic        fast;
    } pending_t;

    logic                                clk;
    logic                                rst;
    logic                                cpu_read;
    logic                                cpu_write;
    logic [31:0]                         cpu_addr;
    logic [31:0]                         cpu_wdata;
    logic [3:0]                          cpu_byteenable;
    logic                                cpu_stall;
    logic                                cpu_rvalid;
    logic [31:0]                         cpu_rdata;
    logic                                mem_rd;
    logic                                mem_wr;
    logic [31:0]                         mem_addr;
    logic [31:0]                         mem_wdata;
    logic                                mem_rvalid;
    logic [31:0]                         mem_rdata;
    logic                                mem_wready;
    logic                                wb_done;
    logic [31:0]                         wb_addr;
    logic [`DCACHE_LINE_WORDS-1:0][31:0] wb_line;

    entry_t      stim [N_ENTRIES];
    logic [31:0] shadow [logic [29:0]];
    pending_t    pending [$];
    int          tick;
    int          wb_count = 0;

    dcache_top u_dcache_top (
        .clk, .rst, .cpu_read, .cpu_write, .cpu_addr, .cpu_wdata, .cpu_byteenable,
        .cpu_stall, .cpu_rvalid, .cpu_rdata,
        .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata, .mem_wready
    );

    tb_mem_model #(.SEED(SEED)) u_mem_model (
        .clk, .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_rvalid, .mem_rdata,
        .mem_wready, .wb_done, .wb_addr, .wb_line
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected));
        end
    endtask

    // Same contents as the memory model before any write
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5ace_0f17;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        return shadow.exists(addr[31:2]) ? shadow[addr[31:2]] : initial_word(addr);
    endfunction

    function automatic entry_t make_entry(input logic [1:0] op, input logic [31:0] addr,
                                          input logic [31:0] wdata, input logic [3:0] be,
                                          input logic fast);
        return '{op: op, addr: addr, wdata: wdata, be: be, fast: fast};
    endfunction

    task automatic load_table();
        // Cold misses and then hits on the same line
        stim[0]  = make_entry(OP_RD, 32'h0000_1000, 32'h0, 4'h0, 1'b0);
        stim[1]  = make_entry(OP_RD, 32'h0000_1004, 32'h0, 4'h0, 1'b0);
        stim[2]  = make_entry(OP_RD, 32'h0000_1008, 32'h0, 4'h0, 1'b1);
        stim[3]  = make_entry(OP_RD, 32'h0000_100c, 32'h0, 4'h0, 1'b1);
        stim[4]  = make_entry(OP_RD, 32'h0000_1000, 32'h0, 4'h0, 1'b1);
        // Partial writes followed at once by reads for forwarding
        stim[5]  = make_entry(OP_WR, 32'h0000_1004, 32'ha1b2_c3d4, 4'h3, 1'b0);
        stim[6]  = make_entry(OP_RD, 32'h0000_1004, 32'h0, 4'h0, 1'b1);
        stim[7]  = make_entry(OP_WR, 32'h0000_1008, 32'hee00_0000, 4'h8, 1'b0);
        stim[8]  = make_entry(OP_WR, 32'h0000_1008, 32'h0077_0000, 4'h4, 1'b0);
        stim[9]  = make_entry(OP_RD, 32'h0000_1008, 32'h0, 4'h0, 1'b1);
        stim[10] = make_entry(OP_RD, 32'h0000_1004, 32'h0, 4'h0, 1'b1);
        stim[11] = make_entry(OP_WR, 32'h0000_2014, 32'h1234_5678, 4'h6, 1'b0);
        stim[12] = make_entry(OP_RD, 32'h0000_2014, 32'h0, 4'h0, 1'b0);
        // Three lines in set 2 force dirty evictions
        stim[13] = make_entry(OP_WR, 32'h0000_3020, 32'h3333_0001, 4'hf, 1'b0);
        stim[14] = make_entry(OP_WR, 32'h0000_4024, 32'h4444_0002, 4'hf, 1'b0);
        stim[15] = make_entry(OP_WR, 32'h0000_5028, 32'h5555_0003, 4'hf, 1'b0);
        stim[16] = make_entry(OP_RD, 32'h0000_3020, 32'h0, 4'h0, 1'b0);
        stim[17] = make_entry(OP_RD, 32'h0000_4024, 32'h0, 4'h0, 1'b0);
        stim[18] = make_entry(OP_RD, 32'h0000_5028, 32'h0, 4'h0, 1'b0);
        stim[19] = make_entry(OP_RD, 32'h0000_302c, 32'h0, 4'h0, 1'b0);
    endtask

    // Called only when cpu_stall is low, so the request is taken at the next edge
    task automatic apply_entry(input entry_t e);
        logic [31:0] word;
        pending_t    p;
        cpu_read       = e.op == OP_RD;
        cpu_write      = e.op == OP_WR;
        cpu_addr       = e.addr;
        cpu_wdata      = e.wdata;
        cpu_byteenable = e.be;
        word = shadow_word(e.addr);
        if (e.op == OP_WR) begin
            for (int b = 0; b < 4; b++) begin
                if (e.be[b]) begin
                    word[8*b +: 8] = e.wdata[8*b +: 8];
                end
            end
            shadow[e.addr[31:2]] = word;
        end else begin
            p.data = word;
            p.tick = tick;
            p.fast = e.fast;
            pending.push_back(p);
        end
    endtask

    task automatic take_result();
        pending_t p;
        if (pending.size() == 0) begin
            abort_run("cpu_rvalid was high with no read outstanding");
        end else begin
            p = pending.pop_front();
            check("cpu_rdata", cpu_rdata, p.data);
            if (p.fast) begin
                check("cpu_rvalid latency", 32'(tick - p.tick), 32'd2);
            end
        end
    endtask

    // Evicted lines must carry the latest written data
    always @(posedge clk) begin
        if (wb_done) begin
            wb_count++;
            check("mem_addr", wb_addr % (4 * `DCACHE_LINE_WORDS), 32'd0);
            for (int i = 0; i < `DCACHE_LINE_WORDS; i++) begin
                check("mem_wdata", wb_line[i], shadow_word(wb_addr + 32'(4 * i)));
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Run timed out after %0d clock cycles", WATCHDOG_CYCLES));
    end

    initial begin
        int idx;
        int sweep_cycles;
        rst            = 1'b1;
        cpu_read       = 1'b0;
        cpu_write      = 1'b0;
        cpu_addr       = '0;
        cpu_wdata      = '0;
        cpu_byteenable = '0;
        tick           = 0;
        load_table();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Tag sweep keeps the cache busy and the buses quiet
        sweep_cycles = 0;
        while (cpu_stall) begin
            check("mem_rd", 32'(mem_rd), 32'd0);
            check("mem_wr", 32'(mem_wr), 32'd0);
            check("cpu_rvalid", 32'(cpu_rvalid), 32'd0);
            sweep_cycles++;
            @(negedge clk);
        end
        check("cpu_stall after reset", 32'(sweep_cycles >= `DCACHE_SETS), 32'd1);

        idx = 0;
        while (idx < N_ENTRIES || pending.size() != 0) begin
            @(negedge clk);
            tick++;
            if (mem_rd || mem_wr) begin
                check("cpu_stall", 32'(cpu_stall), 32'd1);
            end
            if (cpu_rvalid) begin
                take_result();
            end
            if (!cpu_stall) begin
                if (idx < N_ENTRIES) begin
                    apply_entry(stim[idx]);
                    idx++;
                end else begin
                    cpu_read  = 1'b0;
                    cpu_write = 1'b0;
                end
            end
        end
        check("writeback bursts seen", 32'(wb_count != 0), 32'd1);
        $display("TB PASSED");
        $finish;
    end
endmodule

`default_nettype wire

//--- dcache.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_if.sv
verilog/dcache_ram.sv
verilog/dcache_decode.sv
verilog/dcache_execute.sv
verilog/dcache_result.sv
verilog/dcache_top.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

.PHONY: sim clean

# The run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
